// File: src/isaPkg.sv
package isaPkg;

   // datapath and register file
   localparam int dataW    = 16;
   localparam int regCount = 8;
   localparam int regSelW  = 3;

   // memories are word addressed
   localparam int imemDepth = 256;
   localparam int dmemDepth = 256;
   localparam int addrW     = 8;

   // instruction fields
   localparam int opMsb  = 15;
   localparam int opLsb  = 12;
   localparam int rdMsb  = 11;
   localparam int rdLsb  = 9;
   localparam int rsMsb  = 8;
   localparam int rsLsb  = 6;
   localparam int rtMsb  = 5;
   localparam int rtLsb  = 3;
   localparam int immMsb = 5;   // signed 6-bit immediate
   localparam int immLsb = 0;
   localparam int immW   = 6;

   typedef enum logic [3:0] {
      opNop  = 4'd0,
      opAdd  = 4'd1,
      opSub  = 4'd2,
      opAnd  = 4'd3,
      opXor  = 4'd4,
      opAddi = 4'd5,
      opLd   = 4'd6,
      opSt   = 4'd7,   // store data comes from rd
      opBeqz = 4'd8,
      opHalt = 4'd15
   } opcodeT;

endpackage

// File: src/pipePkg.sv
package pipePkg;

   // fetch to decode
   typedef struct packed {
      logic [isaPkg::dataW-1:0] instr;
      logic [isaPkg::addrW-1:0] pcNext;
   } ifIdT;

   // decode to execute
   typedef struct packed {
      isaPkg::opcodeT             op;
      logic [isaPkg::regSelW-1:0] rd;
      logic [isaPkg::dataW-1:0]   opA;      // value of rs
      logic [isaPkg::dataW-1:0]   opB;      // value of rt
      logic [isaPkg::dataW-1:0]   imm;      // already sign extended
      logic [isaPkg::dataW-1:0]   stData;   // value of rd for ST
      logic [isaPkg::addrW-1:0]   pcNext;
      logic                       regWrite;
      logic                       memRead;
      logic                       memWrite;
      logic                       branch;
      logic                       halt;
      logic                       illegal;
   } idExT;

   // execute to memory
   typedef struct packed {
      logic [isaPkg::dataW-1:0]   aluRes;
      logic [isaPkg::dataW-1:0]   stData;
      logic [isaPkg::regSelW-1:0] rd;
      logic                       regWrite;
      logic                       memRead;
      logic                       memWrite;
      logic                       halt;
      logic                       illegal;
   } exMemT;

   // memory to retire
   typedef struct packed {
      logic [isaPkg::dataW-1:0]   result;
      logic [isaPkg::regSelW-1:0] rd;
      logic                       regWrite;
      logic                       halt;
      logic                       illegal;
   } memWbT;

endpackage

// File: src/pipeReg.sv
`timescale 1ns/1ps

module pipeReg #(
   parameter type payloadT = logic
) (
   input  logic    clk,
   input  logic    arstN,
   input  logic    hold,
   input  logic    flush,
   input  logic    inValid,
   input  payloadT inData,
   output logic    outValid,
   output payloadT outData
);

   // hold wins over flush so a frozen stage keeps its instruction
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         outValid <= 1'b0;
      end else if (!hold) begin
         outValid <= inValid && !flush;
      end
   end

   always_ff @(posedge clk) begin
      if (!hold) outData <= inData;   // payload follows the valid bit
   end

   holdStable: assert property (@(posedge clk) disable iff (!arstN)
      hold && !flush |=> $stable(outValid) && $stable(outData));

endmodule

// File: src/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
   input  logic                     clk,
   input  logic                     arstN,
   input  logic                     hold,
   input  logic                     stall,
   input  logic                     redirect,
   input  logic [isaPkg::addrW-1:0] target,
   output logic                     fetchValid,
   output pipePkg::ifIdT            fetchData
);

   logic [isaPkg::dataW-1:0] rom [isaPkg::imemDepth];
   logic [isaPkg::addrW-1:0] pc;
   logic [isaPkg::addrW-1:0] pcNext;

   // words past the end of the program read as NOP
   initial begin
      for (int i = 0; i < isaPkg::imemDepth; i++) begin
         rom[i] = '0;
      end
      $readmemh("tb/prog.hex", rom);
   end

   assign pcNext = pc + 1'b1;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc <= '0;
      end else if (!hold) begin
         if (redirect) pc <= target;      // taken branch beats a stall
         else if (!stall) pc <= pcNext;
      end
   end

   // wrong-path word during a redirect
   assign fetchValid       = !redirect;
   assign fetchData.instr  = rom[pc];
   assign fetchData.pcNext = pcNext;

endmodule

// File: src/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
   input  logic                       clk,
   input  logic                       arstN,
   input  logic                       inValid,
   input  pipePkg::ifIdT              inData,
   input  logic                       idExValid,    // later stages, for hazards
   input  pipePkg::idExT              idExData,
   input  logic                       exMemValid,
   input  pipePkg::exMemT             exMemData,
   input  logic                       memWbValid,
   input  pipePkg::memWbT             memWbData,
   input  logic                       wbEn,
   input  logic [isaPkg::regSelW-1:0] wbReg,
   input  logic [isaPkg::dataW-1:0]   wbData,
   output logic                       stall,
   output logic                       outValid,
   output pipePkg::idExT              outData
);

   logic [isaPkg::dataW-1:0]   regs [isaPkg::regCount];
   isaPkg::opcodeT             op;
   logic [isaPkg::regSelW-1:0] rd, rs, rt;
   logic                       useRs, useRt, useRd;
   logic [isaPkg::regCount-1:0] busy;   // regs with a write in flight

   assign op = isaPkg::opcodeT'(inData.instr[isaPkg::opMsb:isaPkg::opLsb]);
   assign rd = inData.instr[isaPkg::rdMsb:isaPkg::rdLsb];
   assign rs = inData.instr[isaPkg::rsMsb:isaPkg::rsLsb];
   assign rt = inData.instr[isaPkg::rtMsb:isaPkg::rtLsb];

   // register file reads the old value during a same-cycle write
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < isaPkg::regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (wbEn) begin
         regs[wbReg] <= wbData;
      end
   end

   always_comb begin
      outData          = '0;
      outData.op       = op;
      outData.rd       = rd;
      outData.opA      = regs[rs];
      outData.opB      = regs[rt];
      outData.stData   = regs[rd];
      outData.pcNext   = inData.pcNext;
      outData.imm      = {{(isaPkg::dataW - isaPkg::immW){inData.instr[isaPkg::immMsb]}},
                          inData.instr[isaPkg::immMsb:isaPkg::immLsb]};
      useRs = 1'b0;
      useRt = 1'b0;
      useRd = 1'b0;
      case (op)
         isaPkg::opNop: ;
         isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opXor: begin
            outData.regWrite = 1'b1;
            useRs = 1'b1;
            useRt = 1'b1;
         end
         isaPkg::opAddi: begin
            outData.regWrite = 1'b1;
            useRs = 1'b1;
         end
         isaPkg::opLd: begin
            outData.regWrite = 1'b1;
            outData.memRead  = 1'b1;
            useRs = 1'b1;
         end
         isaPkg::opSt: begin
            outData.memWrite = 1'b1;
            useRs = 1'b1;
            useRd = 1'b1;   // store data
         end
         isaPkg::opBeqz: begin
            outData.branch = 1'b1;
            useRs = 1'b1;
         end
         isaPkg::opHalt: outData.halt = 1'b1;
         default: outData.illegal = 1'b1;   // otherwise a NOP
      endcase
   end

   always_comb begin
      busy = '0;
      if (idExValid && idExData.regWrite) busy[idExData.rd] = 1'b1;
      if (exMemValid && exMemData.regWrite) busy[exMemData.rd] = 1'b1;
      if (memWbValid && memWbData.regWrite) busy[memWbData.rd] = 1'b1;
   end

   assign stall = inValid && ((useRs && busy[rs]) || (useRt && busy[rt]) ||
                              (useRd && busy[rd]));
   assign outValid = inValid && !stall;   // bubble while stalled

   wbRegKnown: assert property (@(posedge clk) disable iff (!arstN)
      wbEn |-> !$isunknown(wbReg));

endmodule

// File: src/executeStage.sv
`timescale 1ns/1ps

module executeStage (
   input  logic                     inValid,
   input  pipePkg::idExT            inData,
   output logic                     outValid,
   output pipePkg::exMemT           outData,
   output logic                     redirect,
   output logic [isaPkg::addrW-1:0] target
);

   logic [isaPkg::dataW-1:0] aluRes;

   always_comb begin
      case (inData.op)
         isaPkg::opAdd:  aluRes = inData.opA + inData.opB;
         isaPkg::opSub:  aluRes = inData.opA - inData.opB;
         isaPkg::opAnd:  aluRes = inData.opA & inData.opB;
         isaPkg::opXor:  aluRes = inData.opA ^ inData.opB;
         isaPkg::opAddi,
         isaPkg::opLd,
         isaPkg::opSt:   aluRes = inData.opA + inData.imm;   // also the memory address
         default:        aluRes = inData.opA;
      endcase
   end

   // beqz tests rs and branches relative to pc+1
   assign redirect = inValid && inData.branch && (inData.opA == '0);
   assign target   = inData.pcNext + inData.imm[isaPkg::addrW-1:0];

   assign outValid         = inValid;
   assign outData.aluRes   = aluRes;
   assign outData.stData   = inData.stData;
   assign outData.rd       = inData.rd;
   assign outData.regWrite = inData.regWrite;
   assign outData.memRead  = inData.memRead;
   assign outData.memWrite = inData.memWrite;
   assign outData.halt     = inData.halt;
   assign outData.illegal  = inData.illegal;

endmodule

// File: src/memStage.sv
`timescale 1ns/1ps

module memStage (
   input  logic            clk,
   input  logic            hold,
   input  logic            inValid,
   input  pipePkg::exMemT  inData,
   output logic            outValid,
   output pipePkg::memWbT  outData
);

   logic [isaPkg::dataW-1:0] dmem [isaPkg::dmemDepth];
   logic [isaPkg::addrW-1:0] addr;

   assign addr = inData.aluRes[isaPkg::addrW-1:0];   // low bits only

   // a frozen pipeline must not store twice
   always_ff @(posedge clk) begin
      if (inValid && inData.memWrite && !hold) begin
         dmem[addr] <= inData.stData;
      end
   end

   assign outValid         = inValid;
   assign outData.result   = inData.memRead ? dmem[addr] : inData.aluRes;
   assign outData.rd       = inData.rd;
   assign outData.regWrite = inData.regWrite;
   assign outData.halt     = inData.halt;
   assign outData.illegal  = inData.illegal;

endmodule

// File: src/retireStage.sv
`timescale 1ns/1ps

module retireStage (
   input  logic                       clk,
   input  logic                       arstN,
   input  logic                       inValid,
   input  pipePkg::memWbT             inData,
   input  logic                       retReady,
   output logic                       retValid,
   output logic [isaPkg::regSelW-1:0] retReg,
   output logic [isaPkg::dataW-1:0]   retData,
   output logic                       wbEn,
   output logic [isaPkg::regSelW-1:0] wbReg,
   output logic [isaPkg::dataW-1:0]   wbData,
   output logic                       hold,
   output logic                       halted,
   output logic                       err
);

   assign retValid = inValid && inData.regWrite && !halted;
   assign retReg   = inData.rd;
   assign retData  = inData.result;

   // writeback only on an accepted trace
   assign wbEn   = retValid && retReady;
   assign wbReg  = inData.rd;
   assign wbData = inData.result;

   assign hold = halted || (retValid && !retReady);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (inValid && !hold) begin
         if (inData.halt) halted <= 1'b1;
         if (inData.illegal) err <= 1'b1;   // sticky
      end
   end

   traceStable: assert property (@(posedge clk) disable iff (!arstN)
      retValid && !retReady |=> retValid && $stable(retReg) && $stable(retData));

endmodule

// File: src/proc.sv
`timescale 1ns/1ps

module proc (
   input  logic                       clk,
   input  logic                       arstN,
   output logic                       retValid,
   input  logic                       retReady,
   output logic [isaPkg::regSelW-1:0] retReg,
   output logic [isaPkg::dataW-1:0]   retData,
   output logic                       halted,
   output logic                       err
);

   logic                       hold, stall, redirect;
   logic [isaPkg::addrW-1:0]   target;
   logic                       wbEn;
   logic [isaPkg::regSelW-1:0] wbReg;
   logic [isaPkg::dataW-1:0]   wbData;

   logic fetchValid, ifIdValid, decValid, idExValid;
   logic exValid, exMemValid, memValid, memWbValid;
   pipePkg::ifIdT  fetchData, ifIdData;
   pipePkg::idExT  decData, idExData;
   pipePkg::exMemT exData, exMemData;
   pipePkg::memWbT memData, memWbData;

   // stalled word stays in decode unless a branch flushes it
   wire ifIdHold = hold || (stall && !redirect);

   fetchStage fetch0 (.clk(clk), .arstN(arstN), .hold(hold), .stall(stall),
      .redirect(redirect), .target(target), .fetchValid(fetchValid), .fetchData(fetchData));

   pipeReg #(.payloadT(pipePkg::ifIdT)) ifIdReg (.clk(clk), .arstN(arstN),
      .hold(ifIdHold), .flush(redirect), .inValid(fetchValid), .inData(fetchData),
      .outValid(ifIdValid), .outData(ifIdData));

   decodeStage decode0 (.clk(clk), .arstN(arstN), .inValid(ifIdValid), .inData(ifIdData),
      .idExValid(idExValid), .idExData(idExData), .exMemValid(exMemValid),
      .exMemData(exMemData), .memWbValid(memWbValid), .memWbData(memWbData),
      .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
      .stall(stall), .outValid(decValid), .outData(decData));

   pipeReg #(.payloadT(pipePkg::idExT)) idExReg (.clk(clk), .arstN(arstN),
      .hold(hold), .flush(redirect), .inValid(decValid), .inData(decData),
      .outValid(idExValid), .outData(idExData));

   executeStage execute0 (.inValid(idExValid), .inData(idExData), .outValid(exValid),
      .outData(exData), .redirect(redirect), .target(target));

   pipeReg #(.payloadT(pipePkg::exMemT)) exMemReg (.clk(clk), .arstN(arstN),
      .hold(hold), .flush(1'b0), .inValid(exValid), .inData(exData),
      .outValid(exMemValid), .outData(exMemData));

   memStage mem0 (.clk(clk), .hold(hold), .inValid(exMemValid), .inData(exMemData),
      .outValid(memValid), .outData(memData));

   pipeReg #(.payloadT(pipePkg::memWbT)) memWbReg (.clk(clk), .arstN(arstN),
      .hold(hold), .flush(1'b0), .inValid(memValid), .inData(memData),
      .outValid(memWbValid), .outData(memWbData));

   retireStage retire0 (.clk(clk), .arstN(arstN), .inValid(memWbValid),
      .inData(memWbData), .retReady(retReady), .retValid(retValid), .retReg(retReg),
      .retData(retData), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .hold(hold),
      .halted(halted), .err(err));

endmodule

// File: tb/procTb.sv
`timescale 1ns/1ps

module procTb;

   localparam int progWords  = 20;
   localparam int cycleLimit = 40 * progWords;
   localparam int bpStart    = 100;   // ready stays high until here

   logic                       clk;
   logic                       arstN;
   logic                       retValid;
   logic                       retReady;
   logic [isaPkg::regSelW-1:0] retReg;
   logic [isaPkg::dataW-1:0]   retData;
   logic                       halted;
   logic                       err;

   // expected trace from the reference model
   logic [isaPkg::regSelW-1:0] expRegQ[$];
   logic [isaPkg::dataW-1:0]   expDataQ[$];
   int                         expCount;
   logic                       expErr;

   // architectural state of the model
   logic [15:0] modelRom  [256];
   logic [15:0] modelRegs [8];
   logic [15:0] modelMem  [256];

   int                         errCount;
   int                         retCount;
   int                         cycles;
   integer                     seed;
   logic [isaPkg::regSelW-1:0] wantReg;
   logic [isaPkg::dataW-1:0]   wantData;

   // trace offered but refused at the last edge
   logic                       pendValid;
   logic [isaPkg::regSelW-1:0] pendReg;
   logic [isaPkg::dataW-1:0]   pendData;

   proc dut0 (
      .clk(clk),
      .arstN(arstN),
      .retValid(retValid),
      .retReady(retReady),
      .retReg(retReg),
      .retData(retData),
      .halted(halted),
      .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // runs the program at ISA level until HALT
   function void buildExpected();
      logic [7:0]  pc;
      logic [15:0] instr;
      logic [15:0] imm;
      logic [15:0] res;
      logic [15:0] addr;
      logic [3:0]  op;
      logic [2:0]  rd;
      logic [2:0]  rs;
      logic [2:0]  rt;
      logic        done;
      int          steps;
      for (int i = 0; i < 256; i++) begin
         modelRom[i] = 16'h0000;   // unused words are NOP
         modelMem[i] = 16'h0000;
      end
      for (int i = 0; i < 8; i++) begin
         modelRegs[i] = 16'h0000;
      end
      $readmemh("tb/prog.hex", modelRom);
      pc       = 8'd0;
      done     = 1'b0;
      steps    = 0;
      expCount = 0;
      expErr   = 1'b0;
      while (!done && steps < 4096) begin
         instr = modelRom[pc];
         op    = instr[15:12];
         rd    = instr[11:9];
         rs    = instr[8:6];
         rt    = instr[5:3];
         imm   = {{10{instr[5]}}, instr[5:0]};
         addr  = modelRegs[rs] + imm;
         res   = 16'h0000;
         pc    = pc + 8'd1;
         steps++;
         case (op)
            4'd1: res = modelRegs[rs] + modelRegs[rt];
            4'd2: res = modelRegs[rs] - modelRegs[rt];
            4'd3: res = modelRegs[rs] & modelRegs[rt];
            4'd4: res = modelRegs[rs] ^ modelRegs[rt];
            4'd5: res = addr;                            // addi
            4'd6: res = modelMem[addr[7:0]];             // ld
            4'd7: modelMem[addr[7:0]] = modelRegs[rd];   // st data from rd
            4'd8: begin
               if (modelRegs[rs] == 16'h0000) pc = pc + imm[7:0];   // relative to pc+1
            end
            4'd15: done = 1'b1;
            default: ;
         endcase
         if (op inside {[4'd1:4'd6]}) begin
            modelRegs[rd] = res;
            expRegQ.push_back(rd);
            expDataQ.push_back(res);
            expCount++;
         end else if (op inside {[4'd9:4'd14]}) begin
            expErr = 1'b1;   // illegal word acts as a nop
         end
      end
      if (!done) begin
         $display("reference model never reached HALT");
         errCount++;
      end
   endfunction

   // trace monitor and comparison
   always @(posedge clk) begin
      if (!arstN) begin
         pendValid <= 1'b0;
      end else begin
         if (pendValid) begin
            if (!retValid) begin
               $display("retValid dropped before the trace was accepted");
               errCount++;
            end else begin
               if (retReg !== pendReg) begin
                  $display("ERR retReg changed while waiting: got 0x%h held 0x%h",
                           retReg, pendReg);
                  errCount++;
               end
               if (retData !== pendData) begin
                  $display("ERR retData changed while waiting: got 0x%h held 0x%h",
                           retData, pendData);
                  errCount++;
               end
            end
         end
         if (halted && retValid) begin
            $display("trace offered after the processor halted");
            errCount++;
         end
         if (retValid && retReady) begin
            retCount++;
            if (expRegQ.size() == 0) begin
               $display("trace of r%0d beyond the end of the expected sequence", retReg);
               errCount++;
            end else begin
               wantReg  = expRegQ.pop_front();
               wantData = expDataQ.pop_front();
               if (retReg !== wantReg) begin
                  $display("ERR retReg: got 0x%h expected 0x%h", retReg, wantReg);
                  errCount++;
               end
               if (retData !== wantData) begin
                  $display("ERR retData: got 0x%h expected 0x%h", retData, wantData);
                  errCount++;
               end
            end
         end
         pendValid <= retValid && !retReady;
         pendReg   <= retReg;
         pendData  <= retData;
      end
   end

   initial begin
      seed      = 54;
      arstN     = 1'b0;
      retReady  = 1'b1;
      errCount  = 0;
      retCount  = 0;
      cycles    = 0;
      buildExpected();
      repeat (2) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;
      while (!halted && cycles < cycleLimit) begin
         @(negedge clk);
         cycles++;
         if (cycles >= bpStart) begin
            retReady = ({$random(seed)} % 3) != 0;   // low about a third of the time
         end
      end
      if (!halted) begin
         $display("timeout: processor never halted within %0d cycles", cycleLimit);
         errCount++;
      end else begin
         retReady = 1'b1;
         repeat (10) @(negedge clk);   // window for a stray trace after halt
      end
      if (expRegQ.size() != 0) begin
         $display("%0d expected register writes never showed up", expRegQ.size());
         errCount++;
      end
      if (retCount != expCount) begin
         $display("retired %0d register writes but the model expects %0d",
                  retCount, expCount);
         errCount++;
      end
      if (err !== expErr) begin
         $display("ERR err: got 0x%h expected 0x%h", err, expErr);
         errCount++;
      end
      $display("errors: %0d  retired: %0d  cycles: %0d", errCount, retCount, cycles);
      if (errCount == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// File: src.f
src/isaPkg.sv
src/pipePkg.sv
src/pipeReg.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memStage.sv
src/retireStage.sv
src/proc.sv
tb/procTb.sv

// File: Makefile
# Verilator build and run for the pipelined processor testbench

SRCS := $(wildcard src/*.sv) $(wildcard tb/*.sv)

.PHONY: all run clean

all: obj_dir/VprocTb

obj_dir/VprocTb: src.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module procTb -f src.f -o VprocTb

run: obj_dir/VprocTb
	./obj_dir/VprocTb | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/prog.hex
// one 16-bit instruction word per line, from address 0
// fields: op [15:12], rd [11:9], rs [8:6], rt [5:3] or signed imm [5:0]
5210 // addi r1, r0, 16   loop count
5403 // addi r2, r0, 3
1650 // add  r3, r1, r2
28D0 // sub  r4, r3, r2
3AC8 // and  r5, r3, r1
4D18 // xor  r6, r4, r3
7C0A // st   r6, 10(r0)
6A87 // ld   r5, 7(r2)    same word as the store
14A8 // add  r2, r2, r5   loop body
527F // addi r1, r1, -1
8042 // beqz r1, +2       exit, skips the next two
81FC // beqz r7, -4       always taken, back to the body
5D81 // addi r6, r6, 1    never reached
B123 // illegal opcode
5939 // addi r4, r4, -7
8102 // beqz r4, +2       not taken
3AA0 // and  r5, r2, r4
F000 // halt
56C1 // addi r3, r3, 1    behind halt, never retires
56C2 // addi r3, r3, 2
